//--- verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width
`define RV_XLEN     32

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

`define RV_NREGS    32  // x0 included

`endif

//--- verilog/rv_pkg.sv
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [31:0]         addr_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [3:0]          strb_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE,
    BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_op_e;

  typedef enum logic [2:0] {
    MEM_NONE, MEM_LB, MEM_LBU, MEM_LW, MEM_SB, MEM_SW
  } mem_op_e;

  typedef struct packed {
    addr_t pc;
    word_t instr;
  } fetch_t;

  typedef struct packed {
    addr_t    pc;
    reg_idx_t rd;
    logic     wb_en;
    alu_op_e  alu_op;
    br_op_e   br_op;
    mem_op_e  mem_op;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    imm;
    logic     halt;
  } decode_t;

  typedef struct packed {
    addr_t    pc;
    reg_idx_t rd;
    logic     wb_en;
    mem_op_e  mem_op;
    word_t    result;     // alu result or link address
    word_t    store_data;
    logic     halt;
  } exec_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     wb_en;
    word_t    data;
    logic     halt;
  } wb_t;

  typedef struct packed {
    addr_t addr;  // word aligned
    word_t wdata;
    strb_t wstrb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    addr_t next_pc;
  } redirect_t;

endpackage

`default_nettype wire

//--- verilog/ifu.sv
`default_nettype none
`include "rv_macros.svh"

module ifu (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect_valid_i,
  input  rv_pkg::redirect_t redirect_i,
  output rv_pkg::mem_req_t  mem_req_o,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  input  rv_pkg::mem_rsp_t  mem_rsp_i,
  input  logic              mem_rsp_valid_i,
  output logic              mem_rsp_ready_o,
  output rv_pkg::fetch_t    fetch_o,
  output logic              fetch_valid_o,
  input  logic              fetch_ready_i
);

  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RSP, HAND_OFF} state_e;

  state_e        state;
  rv_pkg::addr_t pc;
  rv_pkg::word_t instr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= REQUEST;  // boot fetch right away
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        IDLE: begin
          if (redirect_valid_i) begin
            pc    <= redirect_i.next_pc;
            state <= REQUEST;
          end
        end
        REQUEST:  if (mem_req_ready_i) state <= WAIT_RSP;
        WAIT_RSP: if (mem_rsp_valid_i) state <= HAND_OFF;
        HAND_OFF: if (fetch_ready_i) state <= IDLE;  // wait for redirect
        default:  state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rsp_valid_i && mem_rsp_ready_o) begin
      instr <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_valid_o = (state == REQUEST);
  assign mem_rsp_ready_o = (state == WAIT_RSP);
  assign fetch_valid_o   = (state == HAND_OFF);

  // fetch is always a plain word read
  assign mem_req_o = '{addr: pc, wdata: '0, wstrb: '0, we: 1'b0};
  assign fetch_o   = '{pc: pc, instr: instr};

endmodule

`default_nettype wire

//--- verilog/idu.sv
`default_nettype none

module idu (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::fetch_t   fetch_i,
  input  logic             fetch_valid_i,
  output logic             fetch_ready_o,
  output rv_pkg::reg_idx_t rs1_o,
  output rv_pkg::reg_idx_t rs2_o,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  output rv_pkg::decode_t  dec_o,
  output logic             dec_valid_o,
  input  logic             dec_ready_i
);

  rv_pkg::word_t   instr;
  logic [2:0]      funct3;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;
  logic            sel_pc;   // op_a from pc
  logic            sel_reg;  // op_b from rs2
  logic            accept;
  rv_pkg::decode_t dec;

  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  assign instr  = fetch_i.instr;
  assign funct3 = instr[14:12];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec            = '0;  // unknown encodings fall out as no-ops
    dec.pc         = fetch_i.pc;
    dec.rd         = instr[11:7];
    dec.alu_op     = rv_pkg::ALU_ADD;
    dec.br_op      = rv_pkg::BR_NONE;
    dec.mem_op     = rv_pkg::MEM_NONE;
    dec.store_data = rs2_data_i;
    dec.imm        = imm_i;
    sel_pc         = 1'b0;
    sel_reg        = 1'b0;
    case (instr[6:0])
      7'b0110111: begin  // lui
        dec.wb_en  = 1'b1;
        dec.alu_op = rv_pkg::ALU_PASS_B;
        dec.imm    = imm_u;
      end
      7'b0010111: begin  // auipc
        dec.wb_en = 1'b1;
        dec.imm   = imm_u;
        sel_pc    = 1'b1;
      end
      7'b1101111: begin
        dec.wb_en = 1'b1;
        dec.br_op = rv_pkg::BR_JAL;
        dec.imm   = imm_j;
      end
      7'b1100111: begin
        dec.wb_en = 1'b1;
        dec.br_op = rv_pkg::BR_JALR;
      end
      7'b1100011: begin
        dec.imm = imm_b;
        sel_reg = 1'b1;  // compare rs1 against rs2
        case (funct3)
          3'b000:  dec.br_op = rv_pkg::BR_BEQ;
          3'b001:  dec.br_op = rv_pkg::BR_BNE;
          3'b100:  dec.br_op = rv_pkg::BR_BLT;
          3'b101:  dec.br_op = rv_pkg::BR_BGE;
          3'b110:  dec.br_op = rv_pkg::BR_BLTU;
          3'b111:  dec.br_op = rv_pkg::BR_BGEU;
          default: dec.br_op = rv_pkg::BR_NONE;
        endcase
      end
      7'b0000011: begin
        case (funct3)
          3'b000:  dec.mem_op = rv_pkg::MEM_LB;
          3'b010:  dec.mem_op = rv_pkg::MEM_LW;
          3'b100:  dec.mem_op = rv_pkg::MEM_LBU;
          default: dec.mem_op = rv_pkg::MEM_NONE;
        endcase
        dec.wb_en = (dec.mem_op != rv_pkg::MEM_NONE);
      end
      7'b0100011: begin
        dec.imm = imm_s;
        case (funct3)
          3'b000:  dec.mem_op = rv_pkg::MEM_SB;
          3'b010:  dec.mem_op = rv_pkg::MEM_SW;
          default: dec.mem_op = rv_pkg::MEM_NONE;
        endcase
      end
      7'b0010011: begin
        dec.wb_en  = 1'b1;
        dec.alu_op = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
      end
      7'b0110011: begin
        dec.wb_en  = !instr[25];  // mul/div group left as no-op
        dec.alu_op = alu_sel(funct3, instr[30]);
        sel_reg    = 1'b1;
      end
      7'b1110011: dec.halt = (instr == 32'h0010_0073);  // ebreak only
      default: ;
    endcase
    dec.op_a = sel_pc ? fetch_i.pc : rs1_data_i;
    dec.op_b = sel_reg ? rs2_data_i : dec.imm;
  end

  assign fetch_ready_o = !dec_valid_o;
  assign accept        = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_o <= dec;
    end
  end

endmodule

`default_nettype wire

//--- verilog/wbu.sv
`default_nettype none
`include "rv_macros.svh"

module wbu (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o,
  input  rv_pkg::wb_t      wb_i,
  input  logic             wb_valid_i,
  output logic             halt_o
);

  rv_pkg::word_t regs [1:`RV_NREGS-1];  // no storage behind x0

  always_ff @(posedge clk) begin
    if (wb_valid_i && wb_i.wb_en && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_o <= 1'b0;
    end else if (wb_valid_i && wb_i.halt) begin
      halt_o <= 1'b1;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- verilog/exu.sv
`default_nettype none

module exu (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::decode_t   dec_i,
  input  logic              dec_valid_i,
  output logic              dec_ready_o,
  output rv_pkg::exec_t     ex_o,
  output logic              ex_valid_o,
  input  logic              ex_ready_i,
  output rv_pkg::redirect_t redirect_o,
  output logic              redirect_valid_o
);

  rv_pkg::word_t alu_res;
  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::addr_t pc_plus4;
  rv_pkg::addr_t next_pc;
  logic          taken;
  logic          is_jump;
  logic          accept;

  assign a = dec_i.op_a;
  assign b = dec_i.op_b;

  always_comb begin
    case (dec_i.alu_op)
      rv_pkg::ALU_ADD:  alu_res = a + b;  // also load/store address
      rv_pkg::ALU_SUB:  alu_res = a - b;
      rv_pkg::ALU_AND:  alu_res = a & b;
      rv_pkg::ALU_OR:   alu_res = a | b;
      rv_pkg::ALU_XOR:  alu_res = a ^ b;
      rv_pkg::ALU_SLL:  alu_res = a << b[4:0];
      rv_pkg::ALU_SRL:  alu_res = a >> b[4:0];
      rv_pkg::ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
      rv_pkg::ALU_SLT:  alu_res = rv_pkg::word_t'($signed(a) < $signed(b));
      rv_pkg::ALU_SLTU: alu_res = rv_pkg::word_t'(a < b);
      default:          alu_res = b;  // lui
    endcase
  end

  // branches see rs1 and rs2 as op_a and op_b
  always_comb begin
    case (dec_i.br_op)
      rv_pkg::BR_BEQ:  taken = (a == b);
      rv_pkg::BR_BNE:  taken = (a != b);
      rv_pkg::BR_BLT:  taken = ($signed(a) < $signed(b));
      rv_pkg::BR_BGE:  taken = ($signed(a) >= $signed(b));
      rv_pkg::BR_BLTU: taken = (a < b);
      rv_pkg::BR_BGEU: taken = (a >= b);
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4 = dec_i.pc + 32'd4;
  assign is_jump  = (dec_i.br_op == rv_pkg::BR_JAL) || (dec_i.br_op == rv_pkg::BR_JALR);

  always_comb begin
    if (dec_i.br_op == rv_pkg::BR_JALR) begin
      next_pc = {alu_res[31:1], 1'b0};
    end else if ((dec_i.br_op == rv_pkg::BR_JAL) || taken) begin
      next_pc = dec_i.pc + dec_i.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign dec_ready_o = !ex_valid_o;
  assign accept      = dec_valid_i && dec_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid_o       <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      redirect_valid_o <= accept && !dec_i.halt;  // no fetch past ebreak
      if (accept) begin
        ex_valid_o <= 1'b1;
      end else if (ex_ready_i) begin
        ex_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_o.pc         <= dec_i.pc;
      ex_o.rd         <= dec_i.rd;
      ex_o.wb_en      <= dec_i.wb_en;
      ex_o.mem_op     <= dec_i.mem_op;
      ex_o.result     <= is_jump ? pc_plus4 : alu_res;
      ex_o.store_data <= dec_i.store_data;
      ex_o.halt       <= dec_i.halt;
      redirect_o      <= '{next_pc: next_pc};
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu.sv
`default_nettype none

module lsu (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::exec_t    ex_i,
  input  logic             ex_valid_i,
  output logic             ex_ready_o,
  output rv_pkg::mem_req_t mem_req_o,
  output logic             mem_req_valid_o,
  input  logic             mem_req_ready_i,
  input  rv_pkg::mem_rsp_t mem_rsp_i,
  input  logic             mem_rsp_valid_i,
  output logic             mem_rsp_ready_o,
  output rv_pkg::wb_t      wb_o,
  output logic             wb_valid_o
);

  typedef enum logic [1:0] {IDLE, REQUEST, WAIT_RSP} state_e;

  state_e        state;
  rv_pkg::exec_t ex_q;
  rv_pkg::word_t lane;
  rv_pkg::word_t load_data;
  logic          accept;
  logic          rsp_done;

  assign ex_ready_o      = (state == IDLE);
  assign mem_req_valid_o = (state == REQUEST);
  assign mem_rsp_ready_o = (state == WAIT_RSP);
  assign accept          = ex_valid_i && ex_ready_o;
  assign rsp_done        = mem_rsp_valid_i && mem_rsp_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= 1'b0;
      case (state)
        IDLE: begin
          if (accept && (ex_i.mem_op == rv_pkg::MEM_NONE)) begin
            wb_valid_o <= 1'b1;  // pass straight through
          end else if (accept) begin
            state <= REQUEST;
          end
        end
        REQUEST: if (mem_req_ready_i) state <= WAIT_RSP;
        WAIT_RSP: begin
          if (mem_rsp_valid_i) begin
            wb_valid_o <= 1'b1;  // store completes here too
            state      <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_q <= ex_i;
      wb_o <= '{rd: ex_i.rd, wb_en: ex_i.wb_en, data: ex_i.result, halt: ex_i.halt};
    end else if (rsp_done) begin
      wb_o.data <= load_data;
    end
  end

  always_comb begin
    mem_req_o.addr  = {ex_q.result[31:2], 2'b00};
    mem_req_o.we    = (ex_q.mem_op == rv_pkg::MEM_SB) || (ex_q.mem_op == rv_pkg::MEM_SW);
    mem_req_o.wdata = ex_q.store_data;
    case (ex_q.mem_op)
      rv_pkg::MEM_SW: mem_req_o.wstrb = 4'b1111;
      rv_pkg::MEM_SB: begin
        mem_req_o.wstrb = 4'b0001 << ex_q.result[1:0];
        mem_req_o.wdata = {4{ex_q.store_data[7:0]}};  // byte on every lane
      end
      default: mem_req_o.wstrb = 4'b0000;
    endcase
  end

  // addressed byte moved down to bits 7:0
  assign lane = mem_rsp_i.rdata >> {ex_q.result[1:0], 3'b000};

  always_comb begin
    case (ex_q.mem_op)
      rv_pkg::MEM_LB:  load_data = {{24{lane[7]}}, lane[7:0]};
      rv_pkg::MEM_LBU: load_data = {24'b0, lane[7:0]};
      default:         load_data = mem_rsp_i.rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::mem_req_t f_req_i,
  input  logic             f_req_valid_i,
  output logic             f_req_ready_o,
  output rv_pkg::mem_rsp_t f_rsp_o,
  output logic             f_rsp_valid_o,
  input  logic             f_rsp_ready_i,
  input  rv_pkg::mem_req_t l_req_i,
  input  logic             l_req_valid_i,
  output logic             l_req_ready_o,
  output rv_pkg::mem_rsp_t l_rsp_o,
  output logic             l_rsp_valid_o,
  input  logic             l_rsp_ready_i,
  output rv_pkg::mem_req_t m_req_o,
  output logic             m_req_valid_o,
  input  logic             m_req_ready_i,
  input  rv_pkg::mem_rsp_t m_rsp_i,
  input  logic             m_rsp_valid_i,
  output logic             m_rsp_ready_o
);

  typedef enum logic [1:0] {IDLE, FETCH_BUSY, LSU_BUSY} state_e;

  state_e state;
  logic   idle;
  logic   pick_lsu;

  assign idle     = (state == IDLE);
  assign pick_lsu = l_req_valid_i;  // lsu wins a tie

  // request side only open while idle
  assign m_req_o       = pick_lsu ? l_req_i : f_req_i;
  assign m_req_valid_o = idle && (l_req_valid_i || f_req_valid_i);
  assign l_req_ready_o = idle && pick_lsu && m_req_ready_i;
  assign f_req_ready_o = idle && !pick_lsu && m_req_ready_i;

  assign f_rsp_o       = m_rsp_i;
  assign l_rsp_o       = m_rsp_i;
  assign f_rsp_valid_o = (state == FETCH_BUSY) && m_rsp_valid_i;
  assign l_rsp_valid_o = (state == LSU_BUSY) && m_rsp_valid_i;

  always_comb begin
    case (state)
      FETCH_BUSY: m_rsp_ready_o = f_rsp_ready_i;
      LSU_BUSY:   m_rsp_ready_o = l_rsp_ready_i;
      default:    m_rsp_ready_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (m_req_valid_o && m_req_ready_i) begin
            state <= pick_lsu ? LSU_BUSY : FETCH_BUSY;
          end
        end
        FETCH_BUSY: if (m_rsp_valid_i && f_rsp_ready_i) state <= IDLE;
        LSU_BUSY:   if (m_rsp_valid_i && l_rsp_ready_i) state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`default_nettype none

module core_top (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::mem_req_t mem_req_o,
  output logic             mem_req_valid_o,
  input  logic             mem_req_ready_i,
  input  rv_pkg::mem_rsp_t mem_rsp_i,
  input  logic             mem_rsp_valid_i,
  output logic             mem_rsp_ready_o,
  output logic             halt_o
);

  rv_pkg::fetch_t    fetch;
  logic              fetch_valid;
  logic              fetch_ready;
  rv_pkg::decode_t   dec;
  logic              dec_valid;
  logic              dec_ready;
  rv_pkg::exec_t     ex;
  logic              ex_valid;
  logic              ex_ready;
  rv_pkg::wb_t       wb;
  logic              wb_valid;
  rv_pkg::redirect_t redirect;
  logic              redirect_valid;
  rv_pkg::reg_idx_t  rs1;
  rv_pkg::reg_idx_t  rs2;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  // fetch and load/store sides of the arbiter
  rv_pkg::mem_req_t  f_req;
  logic              f_req_valid;
  logic              f_req_ready;
  rv_pkg::mem_rsp_t  f_rsp;
  logic              f_rsp_valid;
  logic              f_rsp_ready;
  rv_pkg::mem_req_t  l_req;
  logic              l_req_valid;
  logic              l_req_ready;
  rv_pkg::mem_rsp_t  l_rsp;
  logic              l_rsp_valid;
  logic              l_rsp_ready;

  ifu ifu_i (
    .clk(clk), .rst(rst),
    .redirect_valid_i(redirect_valid), .redirect_i(redirect),
    .mem_req_o(f_req), .mem_req_valid_o(f_req_valid), .mem_req_ready_i(f_req_ready),
    .mem_rsp_i(f_rsp), .mem_rsp_valid_i(f_rsp_valid), .mem_rsp_ready_o(f_rsp_ready),
    .fetch_o(fetch), .fetch_valid_o(fetch_valid), .fetch_ready_i(fetch_ready)
  );

  idu idu_i (
    .clk(clk), .rst(rst),
    .fetch_i(fetch), .fetch_valid_i(fetch_valid), .fetch_ready_o(fetch_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .dec_o(dec), .dec_valid_o(dec_valid), .dec_ready_i(dec_ready)
  );

  wbu wbu_i (
    .clk(clk), .rst(rst),
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .wb_i(wb), .wb_valid_i(wb_valid), .halt_o(halt_o)
  );

  exu exu_i (
    .clk(clk), .rst(rst),
    .dec_i(dec), .dec_valid_i(dec_valid), .dec_ready_o(dec_ready),
    .ex_o(ex), .ex_valid_o(ex_valid), .ex_ready_i(ex_ready),
    .redirect_o(redirect), .redirect_valid_o(redirect_valid)
  );

  lsu lsu_i (
    .clk(clk), .rst(rst),
    .ex_i(ex), .ex_valid_i(ex_valid), .ex_ready_o(ex_ready),
    .mem_req_o(l_req), .mem_req_valid_o(l_req_valid), .mem_req_ready_i(l_req_ready),
    .mem_rsp_i(l_rsp), .mem_rsp_valid_i(l_rsp_valid), .mem_rsp_ready_o(l_rsp_ready),
    .wb_o(wb), .wb_valid_o(wb_valid)
  );

  mem_arbiter mem_arbiter_i (
    .clk(clk), .rst(rst),
    .f_req_i(f_req), .f_req_valid_i(f_req_valid), .f_req_ready_o(f_req_ready),
    .f_rsp_o(f_rsp), .f_rsp_valid_o(f_rsp_valid), .f_rsp_ready_i(f_rsp_ready),
    .l_req_i(l_req), .l_req_valid_i(l_req_valid), .l_req_ready_o(l_req_ready),
    .l_rsp_o(l_rsp), .l_rsp_valid_o(l_rsp_valid), .l_rsp_ready_i(l_rsp_ready),
    .m_req_o(mem_req_o), .m_req_valid_o(mem_req_valid_o), .m_req_ready_i(mem_req_ready_i),
    .m_rsp_i(mem_rsp_i), .m_rsp_valid_i(mem_rsp_valid_i), .m_rsp_ready_o(mem_rsp_ready_o)
  );

endmodule

`default_nettype wire

//--- test/core_sva.sv
`default_nettype none
`include "rv_macros.svh"

module core_sva (
  input wire logic             clk,
  input wire logic             rst,
  input wire rv_pkg::mem_req_t req_i,
  input wire logic             req_valid_i,
  input wire logic             req_ready_i,
  input wire logic             halt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // stalled request keeps valid and payload
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
  else begin
    fail_count++;
    $error("ERR mem_req_o changed while stalled: %h", req_i);
  end

  a_boot_fetch: assert property (@(posedge clk)
    $fell(rst) |-> req_valid_i && !req_i.we && (req_i.addr == `RV_RESET_PC))
  else begin
    fail_count++;
    $error("ERR mem_req_o.addr %h expected %h on first fetch", req_i.addr, `RV_RESET_PC);
  end

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt_i |-> !req_valid_i)
  else begin
    fail_count++;
    $error("ERR mem_req_valid_o %h after halt, addr %h", req_valid_i, req_i.addr);
  end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> halt_i)
  else begin
    fail_count++;
    $error("ERR halt_o %h dropped before reset", halt_i);
  end

endmodule

bind core_top core_sva core_sva_i (
  .clk(clk), .rst(rst),
  .req_i(mem_req_o), .req_valid_i(mem_req_valid_o), .req_ready_i(mem_req_ready_i),
  .halt_i(halt_o)
);

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none
`include "rv_macros.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 2048;
  localparam int NSIG      = 18;
  localparam int NINSTR    = 68;
  localparam int MAX_DELAY = 7;
  localparam int TIMEOUT_CYCLES = NINSTR * 200 * MAX_DELAY;

  logic              clk = 1'b0;
  logic              rst;
  rv_pkg::mem_req_t  mem_req;
  logic              mem_req_valid;
  logic              req_ready;
  rv_pkg::mem_rsp_t  mem_rsp;
  logic              rsp_valid;
  logic              mem_rsp_ready;
  logic              halt;

  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] exp_addr [0:NSIG-1];
  logic [31:0] exp_data [0:NSIG-1];
  logic [3:0]  exp_strb [0:NSIG-1];
  logic [31:0] lfsr_state = 32'h43687fe8;
  logic [2:0]  req_wait;
  logic [2:0]  rsp_wait;
  logic        rsp_pending;
  int          prog_idx;
  int          sig_idx;
  int          store_errors;
  int          sva_errors;

  core_top core_top_i (
    .clk(clk), .rst(rst),
    .mem_req_o(mem_req), .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(req_ready),
    .mem_rsp_i(mem_rsp), .mem_rsp_valid_i(rsp_valid), .mem_rsp_ready_o(mem_rsp_ready),
    .halt_o(halt)
  );

  always #10 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [2:0] pick_delay();
    logic [2:0] d;
    d = '0;
    for (int k = 0; k < 3; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      d = {d[1:0], lfsr_state[0]};
    end
    return d;
  endfunction

  // instruction formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[prog_idx] = w;
    prog_idx++;
  endtask

  // alu op into x4, then stored to the next signature slot
  task automatic alu_case(input logic [31:0] op_word, input logic [11:0] off);
    emit(op_word);
    emit(s_type(off, 5'd4, 5'd1, 3'b010));
  endtask

  // taken skips a bad store, not taken bumps x5
  task automatic br_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic taken);
    emit(b_type(13'd8, rs2, rs1, f3));
    if (taken) emit(s_type(12'h100, 5'd0, 5'd1, 3'b010));
    else emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, 7'b0010011));
  endtask

  task automatic expect_store(input int i, input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s);
    exp_addr[i] = a;
    exp_data[i] = d;
    exp_strb[i] = s;
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (`RV_RESET_PC + 32'(i) * 4) ^ 32'hC3A5_0F96;
    end
    prog_idx = 0;
    emit({20'h80001, 5'd1, 7'b0110111});                    // x1 = signature base
    emit(i_type(12'hFF9, 5'd0, 3'b000, 5'd2, 7'b0010011));  // x2 = -7
    emit(i_type(12'd12, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(i_type(12'd12, 5'd0, 3'b000, 5'd7, 7'b0010011));
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd5, 7'b0010011));
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4), 12'd0);   // add
    alu_case(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd4), 12'd4);   // sub
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd4), 12'd8);   // and
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd4), 12'd12);  // or
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd4), 12'd16);  // xor
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd4), 12'd20);  // slt
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd4), 12'd24);  // sltu
    alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b001, 5'd4), 12'd28);  // sll by 12
    alu_case(i_type(12'h004, 5'd2, 3'b101, 5'd4, 7'b0010011), 12'd32);  // srli 4
    alu_case(i_type(12'h401, 5'd2, 3'b101, 5'd4, 7'b0010011), 12'd36);  // srai 1
    br_case(3'b000, 5'd3, 5'd7, 1'b1);
    br_case(3'b000, 5'd2, 5'd3, 1'b0);
    br_case(3'b001, 5'd2, 5'd3, 1'b1);
    br_case(3'b001, 5'd3, 5'd7, 1'b0);
    br_case(3'b100, 5'd2, 5'd3, 1'b1);
    br_case(3'b100, 5'd3, 5'd2, 1'b0);
    br_case(3'b101, 5'd3, 5'd2, 1'b1);
    br_case(3'b101, 5'd2, 5'd3, 1'b0);
    br_case(3'b110, 5'd3, 5'd2, 1'b1);
    br_case(3'b110, 5'd2, 5'd3, 1'b0);
    br_case(3'b111, 5'd2, 5'd3, 1'b1);
    br_case(3'b111, 5'd3, 5'd2, 1'b0);
    emit(s_type(12'd40, 5'd5, 5'd1, 3'b010));
    emit(j_type(21'd8, 5'd6));                               // jal at 0x800000c8
    emit(s_type(12'h104, 5'd0, 5'd1, 3'b010));
    emit(s_type(12'd44, 5'd6, 5'd1, 3'b010));
    emit({20'h0, 5'd8, 7'b0010111});                         // auipc at 0x800000d4
    emit(i_type(12'd16, 5'd8, 3'b000, 5'd10, 7'b1100111));
    emit(s_type(12'h108, 5'd0, 5'd1, 3'b010));
    emit(s_type(12'h10C, 5'd0, 5'd1, 3'b010));
    emit(s_type(12'd48, 5'd10, 5'd1, 3'b010));
    emit(s_type(12'd52, 5'd8, 5'd1, 3'b010));
    emit(i_type(12'hFB5, 5'd0, 3'b000, 5'd11, 7'b0010011));  // x11 = -75
    emit(s_type(12'd57, 5'd11, 5'd1, 3'b000));                // sb lane 1
    emit(i_type(12'd57, 5'd1, 3'b000, 5'd12, 7'b0000011));
    emit(s_type(12'd60, 5'd12, 5'd1, 3'b010));
    emit(i_type(12'd57, 5'd1, 3'b100, 5'd13, 7'b0000011));
    emit(s_type(12'd64, 5'd13, 5'd1, 3'b010));
    emit(i_type(12'd0, 5'd1, 3'b010, 5'd14, 7'b0000011));
    emit(s_type(12'd68, 5'd14, 5'd1, 3'b010));
    emit(32'h0010_0073);  // ebreak
  endtask

  // worked out by hand from the rv32i rules
  task automatic load_expected();
    expect_store(0,  32'h8000_1000, 32'h0000_0005, 4'hF);
    expect_store(1,  32'h8000_1004, 32'hFFFF_FFED, 4'hF);
    expect_store(2,  32'h8000_1008, 32'h0000_0008, 4'hF);
    expect_store(3,  32'h8000_100C, 32'hFFFF_FFFD, 4'hF);
    expect_store(4,  32'h8000_1010, 32'hFFFF_FFF5, 4'hF);
    expect_store(5,  32'h8000_1014, 32'h0000_0001, 4'hF);
    expect_store(6,  32'h8000_1018, 32'h0000_0000, 4'hF);
    expect_store(7,  32'h8000_101C, 32'hFFFF_9000, 4'hF);
    expect_store(8,  32'h8000_1020, 32'h0FFF_FFFF, 4'hF);
    expect_store(9,  32'h8000_1024, 32'hFFFF_FFFC, 4'hF);
    expect_store(10, 32'h8000_1028, 32'h0000_0006, 4'hF);  // six not-taken
    expect_store(11, 32'h8000_102C, 32'h8000_00CC, 4'hF);
    expect_store(12, 32'h8000_1030, 32'h8000_00DC, 4'hF);
    expect_store(13, 32'h8000_1034, 32'h8000_00D4, 4'hF);
    expect_store(14, 32'h8000_1038, 32'hB5B5_B5B5, 4'b0010);
    expect_store(15, 32'h8000_103C, 32'hFFFF_FFB5, 4'hF);
    expect_store(16, 32'h8000_1040, 32'h0000_00B5, 4'hF);
    expect_store(17, 32'h8000_1044, 32'h0000_0005, 4'hF);
  endtask

  task automatic check_store(input rv_pkg::mem_req_t r);
    if (sig_idx >= NSIG) begin
      store_errors++;
      $display("unexpected store to %h after the last signature entry", r.addr);
    end else begin
      assert (r.addr == exp_addr[sig_idx]) else begin
        store_errors++;
        $display("ERR mem_req_o.addr %h expected %h", r.addr, exp_addr[sig_idx]);
      end
      assert (r.wdata == exp_data[sig_idx]) else begin
        store_errors++;
        $display("ERR mem_req_o.wdata %h expected %h", r.wdata, exp_data[sig_idx]);
      end
      assert (r.wstrb == exp_strb[sig_idx]) else begin
        store_errors++;
        $display("ERR mem_req_o.wstrb %h expected %h", r.wstrb, exp_strb[sig_idx]);
      end
    end
    sig_idx++;
  endtask

  // memory model with random ready and response delays
  always @(posedge clk) begin
    if (rst) begin
      req_ready   <= 1'b0;
      rsp_valid   <= 1'b0;
      rsp_pending <= 1'b0;
      req_wait    <= pick_delay();
      rsp_wait    <= pick_delay();
    end else begin
      if (req_ready && mem_req_valid) begin
        req_ready     <= 1'b0;
        rsp_pending   <= 1'b1;
        mem_rsp.rdata <= mem[mem_req.addr[12:2]];
        if (mem_req.we) begin
          check_store(mem_req);
          for (int b = 0; b < 4; b++) begin
            if (mem_req.wstrb[b]) mem[mem_req.addr[12:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
          end
        end
      end else if (mem_req_valid && !req_ready) begin
        if (req_wait == 0) begin
          req_ready <= 1'b1;
          req_wait  <= pick_delay();
        end else begin
          req_wait <= req_wait - 1'b1;
        end
      end
      if (rsp_valid && mem_rsp_ready) begin
        rsp_valid <= 1'b0;
      end else if (rsp_pending && !rsp_valid) begin
        if (rsp_wait == 0) begin
          rsp_valid   <= 1'b1;
          rsp_pending <= 1'b0;
          rsp_wait    <= pick_delay();
        end else begin
          rsp_wait <= rsp_wait - 1'b1;
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, halt never came", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst           = 1'b1;
    req_ready     = 1'b0;
    rsp_valid     = 1'b0;
    mem_rsp       = '0;
    sig_idx       = 0;
    store_errors  = 0;
    load_program();
    load_expected();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (!halt) @(posedge clk);
    assert (sig_idx == NSIG) else begin
      store_errors++;
      $display("halt came after %0d of %0d signature stores", sig_idx, NSIG);
    end
    repeat (20) @(posedge clk);  // catch traffic after halt
    sva_errors = core_top_i.core_sva_i.fail_count;
    $display("store errors %0d, assertion errors %0d", store_errors, sva_errors);
    if (store_errors == 0 && sva_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/ifu.sv
verilog/idu.sv
verilog/wbu.sv
verilog/exu.sv
verilog/lsu.sv
verilog/mem_arbiter.sv
verilog/core_top.sv
test/core_sva.sv
test/core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module core_tb -f files.f -o core_sim
	./obj_dir/core_sim +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
